// ==== include/dfe_defs.svh ====
// DFE register map
`ifndef DFE_DEFS_SVH
`define DFE_DEFS_SVH

// control, bit 0 enables the feedback path
`define DFE_REG_CTRL    0
// level separation, unsigned
`define DFE_REG_SEP     1
// first tap weight, the others follow at consecutive addresses
`define DFE_REG_TAP0    2
// read-only counters, a write clears them
`define DFE_REG_SYMCNT  8
`define DFE_REG_SATCNT  9

// separation after reset
`define DFE_SEP_DEFAULT 56

`endif

// ==== list.f ====
+incdir+include
verilog/dfe_pkg.sv
verilog/dfe_regs.sv
verilog/dfe_feedback.sv
verilog/pam4_slicer.sv
verilog/dfe_top.sv
tb/dfe_chk.sv
tb/dfe_tb.sv

// ==== tb/dfe_chk.sv ====
// DFE interface assertions
`timescale 1ns/1ps
`default_nettype none

module dfe_chk #(
    parameter int SAMPLE_W = 10
) (
    input wire logic                clk,
    input wire logic                rstn,
    input wire logic                sample_valid,
    input wire logic                sym_valid,
    input wire logic [1:0]          sym,
    input wire logic [2:0]          sym_level,
    input wire logic [SAMPLE_W-1:0] eq_sample,
    input wire logic                wb_cyc,
    input wire logic                wb_stb,
    input wire logic                wb_ack
);

    int fail_cnt = 0;

    // ack only answers an active request
    ack_in_cycle: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |-> (wb_cyc && wb_stb))
        else begin
            $error("wb_ack high outside a bus cycle");
            fail_cnt++;
        end

    ack_one_cycle: assert property (@(posedge clk) disable iff (!rstn)
        wb_ack |=> !wb_ack)
        else begin
            $error("wb_ack held for two cycles");
            fail_cnt++;
        end

    // fixed two-cycle stream latency, both directions
    sym_follows_sample: assert property (@(posedge clk) disable iff (!rstn)
        sample_valid |-> ##2 sym_valid)
        else begin
            $error("sym_valid missing two cycles after sample_valid");
            fail_cnt++;
        end

    sym_has_sample: assert property (@(posedge clk) disable iff (!rstn)
        sym_valid |-> $past(sample_valid, 2))
        else begin
            $error("sym_valid without a sample two cycles earlier");
            fail_cnt++;
        end

    // the width bounds eq_sample, so only unknown bits can break its range
    out_known: assert property (@(posedge clk) disable iff (!rstn)
        sym_valid |-> !$isunknown({sym, sym_level, eq_sample}))
        else begin
            $error("unknown bits on the symbol outputs");
            fail_cnt++;
        end

endmodule

bind dfe_top dfe_chk #(
    .SAMPLE_W (SAMPLE_W)
) chk0 (
    .clk          (clk),
    .rstn         (rstn),
    .sample_valid (sample_valid),
    .sym_valid    (sym_valid),
    .sym          (sym),
    .sym_level    (sym_level),
    .eq_sample    (eq_sample),
    .wb_cyc       (wb_cyc),
    .wb_stb       (wb_stb),
    .wb_ack       (wb_ack)
);

`default_nettype wire

// ==== tb/dfe_tb.sv ====
// PAM4 DFE testbench
`timescale 1ns/1ps
`default_nettype none
`include "dfe_defs.svh"

module dfe_tb
    import dfe_pkg::*;
();

    localparam int SAMPLE_W = 10;
    localparam int NUM_TAPS = 3;
    localparam int WAIT_MAX = 100;

    logic                       clk;
    logic                       rstn;
    logic signed [SAMPLE_W-1:0] sample;
    logic                       sample_valid;
    logic [1:0]                 sym;
    logic signed [2:0]          sym_level;
    logic signed [SAMPLE_W-1:0] eq_sample;
    logic                       sym_valid;
    logic                       wb_cyc;
    logic                       wb_stb;
    logic                       wb_we;
    logic [WB_ADR_W-1:0]        wb_adr;
    logic [WB_DAT_W-1:0]        wb_dat_w;
    logic [WB_DAT_W-1:0]        wb_dat_r;
    logic                       wb_ack;

    // model copies of the registers and the decision history
    int        m_en;
    int        m_sep;
    int        m_sat;
    int        m_tap  [NUM_TAPS];
    int        m_hist [NUM_TAPS];
    int        exp_eq [$];
    int        exp_lvl [$];
    int        tap_set [NUM_TAPS] = '{24, -8, 4};
    int        checks;
    int        errors;
    bit [31:0] rng = 32'd28840;

    dfe_top dut0 (
        .clk          (clk),
        .rstn         (rstn),
        .sample       (sample),
        .sample_valid (sample_valid),
        .sym          (sym),
        .sym_level    (sym_level),
        .eq_sample    (eq_sample),
        .sym_valid    (sym_valid),
        .wb_cyc       (wb_cyc),
        .wb_stb       (wb_stb),
        .wb_we        (wb_we),
        .wb_adr       (wb_adr),
        .wb_dat_w     (wb_dat_w),
        .wb_dat_r     (wb_dat_r),
        .wb_ack       (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic bit [31:0] rand_next();
        rng = rng ^ (rng << 13);
        rng = rng ^ (rng >> 17);
        rng = rng ^ (rng << 5);
        return rng;
    endfunction

    task automatic check_val(input string name, input logic signed [31:0] exp_v, act_v);
        checks++;
        if (exp_v !== act_v) begin
            errors++;
            $display("MISMATCH at %0t: %s expected %0d, got %0d", $time, name, exp_v, act_v);
        end
    endtask

    function automatic int gray_code(input int lvl);
        case (lvl)
            -3:      return 0;
            -1:      return 1;
            1:       return 3;
            3:       return 2;
            default: return -1;
        endcase
    endfunction

    // feedback subtraction, clamp and slicer for one sample
    function automatic void model_step(input int s, output int eq, output int lvl);
        int tsum;
        int isi;
        tsum = 0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            tsum += m_tap[k] * m_hist[k];
        end
        isi = (tsum * (m_sep / 2)) >>> TAP_FRAC;
        eq  = m_en ? s - isi : s;
        if (eq > 511) begin
            eq = 511;
            m_sat++;
        end else if (eq < -512) begin
            eq = -512;
            m_sat++;
        end
        if (eq >= m_sep) lvl = 3;
        else if (eq >= 0) lvl = 1;
        else if (eq >= -m_sep) lvl = -1;
        else lvl = -3;
        for (int k = NUM_TAPS - 1; k > 0; k--) begin
            m_hist[k] = m_hist[k-1];
        end
        m_hist[0] = lvl;
    endfunction

    task automatic wb_cycle(input bit we, input int adr, input int dat, output int rd);
        int t;
        @(posedge clk);
        wb_cyc   <= 1'b1;
        wb_stb   <= 1'b1;
        wb_we    <= we;
        wb_adr   <= WB_ADR_W'(adr);
        wb_dat_w <= WB_DAT_W'(dat);
        t = 0;
        do begin
            @(posedge clk);
            t++;
        end while (!wb_ack && t < WAIT_MAX);
        if (!wb_ack) begin
            errors++;
            $display("no Wishbone ack for address %0d", adr);
        end
        rd = int'(wb_dat_r);
        wb_cyc <= 1'b0;
        wb_stb <= 1'b0;
        wb_we  <= 1'b0;
    endtask

    task automatic wb_write(input int adr, input int dat);
        int rd;
        wb_cycle(1'b1, adr, dat, rd);
        if (adr == `DFE_REG_CTRL) m_en = dat & 1;
        else if (adr == `DFE_REG_SEP) m_sep = dat & 'h3ff;
        else if (adr >= `DFE_REG_TAP0 && adr < `DFE_REG_TAP0 + NUM_TAPS)
            m_tap[adr - `DFE_REG_TAP0] = int'($signed(dat[7:0]));
    endtask

    task automatic wb_read(input int adr, output int rd);
        wb_cycle(1'b0, adr, 0, rd);
    endtask

    task automatic send_sample(input int s, output int lvl);
        int eq;
        model_step(s, eq, lvl);
        exp_eq.push_back(eq);
        exp_lvl.push_back(lvl);
        @(posedge clk);
        sample       <= SAMPLE_W'(s);
        sample_valid <= 1'b1;
    endtask

    task automatic stream_idle(input int n);
        repeat (n) begin
            @(posedge clk);
            sample_valid <= 1'b0;
        end
    endtask

    task automatic drain();
        int t;
        stream_idle(1);
        t = 0;
        while (exp_lvl.size() != 0 && t < WAIT_MAX) begin
            @(posedge clk);
            t++;
        end
        if (exp_lvl.size() != 0) begin
            errors++;
            $display("%0d expected symbols never came out", exp_lvl.size());
            exp_lvl.delete();
            exp_eq.delete();
        end
    endtask

    // every symbol is checked against the oldest queued prediction
    always @(posedge clk) begin : monitor
        int lvl;
        int eq;
        if (rstn && sym_valid) begin
            if (exp_lvl.size() == 0) begin
                errors++;
                $display("symbol at %0t with no sample behind it", $time);
            end else begin
                lvl = exp_lvl.pop_front();
                eq  = exp_eq.pop_front();
                check_val("sym_level", lvl, sym_level);
                check_val("sym", gray_code(lvl), sym);
                check_val("eq_sample", eq, eq_sample);
            end
        end
    end

    task automatic report_test(input string name, input int e0);
        $display("test %-8s %0d errors", name, errors - e0);
    endtask

    task automatic test_regs();
        int e0;
        int rd;
        e0 = errors;
        wb_read(`DFE_REG_CTRL, rd);
        check_val("ctrl", 0, rd);
        wb_read(`DFE_REG_SEP, rd);
        check_val("sep", 56, rd);
        for (int i = 0; i < NUM_TAPS; i++) begin
            wb_read(`DFE_REG_TAP0 + i, rd);
            check_val("tap reset", 0, rd);
            wb_write(`DFE_REG_TAP0 + i, tap_set[i] & 'hffff);
            wb_read(`DFE_REG_TAP0 + i, rd);
            check_val("tap", tap_set[i] & 'hffff, rd);
        end
        wb_write(`DFE_REG_CTRL, 1);
        wb_read(`DFE_REG_CTRL, rd);
        check_val("ctrl", 1, rd);
        wb_write(`DFE_REG_CTRL, 0);
        wb_write(`DFE_REG_SEP, 60);
        wb_read(`DFE_REG_SEP, rd);
        check_val("sep", 60, rd);
        wb_write(`DFE_REG_SEP, 56);
        wb_write(6, 'hffff);
        wb_read(6, rd);
        check_val("unmapped 6", 0, rd);
        wb_read(15, rd);
        check_val("unmapped 15", 0, rd);
        wb_write(`DFE_REG_SYMCNT, 'h1234);
        wb_read(`DFE_REG_SYMCNT, rd);
        check_val("symcnt", 0, rd);
        wb_write(`DFE_REG_SATCNT, 'h55);
        wb_read(`DFE_REG_SATCNT, rd);
        check_val("satcnt", 0, rd);
        report_test("regs", e0);
    endtask

    task automatic test_slicer();
        int e0;
        int lvl;
        int vals [13] = '{0, -1, 1, 55, 56, 57, -55, -56, -57, 511, -512, 200, -200};
        e0 = errors;
        wb_write(`DFE_REG_CTRL, 0);
        foreach (vals[i]) send_sample(vals[i], lvl);
        drain();
        report_test("slicer", e0);
    endtask

    task automatic test_isi();
        int e0;
        int lvl;
        int got;
        int tsum;
        int tx_hist [NUM_TAPS];
        int data [40];
        e0 = errors;
        wb_write(`DFE_REG_CTRL, 1);
        // channel starts from the decisions already held in the DUT
        tx_hist = m_hist;
        foreach (data[n]) begin
            lvl  = 2 * int'(rand_next() % 4) - 3;
            tsum = 0;
            for (int k = 0; k < NUM_TAPS; k++) tsum += m_tap[k] * tx_hist[k];
            data[n] = lvl * (m_sep / 2) + ((tsum * (m_sep / 2)) >>> TAP_FRAC);
            for (int k = NUM_TAPS - 1; k > 0; k--) tx_hist[k] = tx_hist[k-1];
            tx_hist[0] = lvl;
            send_sample(data[n], got);
            // equalized output must give back the transmitted level
            exp_lvl[exp_lvl.size() - 1] = lvl;
        end
        drain();
        wb_write(`DFE_REG_CTRL, 0);
        foreach (data[n]) send_sample(data[n], got);
        drain();
        report_test("isi", e0);
    endtask

    task automatic test_sat();
        int e0;
        int lvl;
        int rd;
        int vals [12] = '{511, 500, 400, -512, -500, -400, 0, 300, -300, 100, 511, -512};
        e0 = errors;
        wb_write(`DFE_REG_CTRL, 1);
        for (int i = 0; i < NUM_TAPS; i++) wb_write(`DFE_REG_TAP0 + i, 127);
        wb_write(`DFE_REG_SATCNT, 0);
        m_sat = 0;
        foreach (vals[i]) send_sample(vals[i], lvl);
        drain();
        wb_read(`DFE_REG_SATCNT, rd);
        check_val("satcnt", m_sat, rd);
        if (m_sat == 0) begin
            errors++;
            $display("saturation test produced no clamp");
        end
        wb_write(`DFE_REG_SATCNT, 0);
        wb_read(`DFE_REG_SATCNT, rd);
        check_val("satcnt cleared", 0, rd);
        report_test("sat", e0);
    endtask

    task automatic test_gaps();
        int e0;
        int lvl;
        int rd;
        e0 = errors;
        for (int i = 0; i < NUM_TAPS; i++) wb_write(`DFE_REG_TAP0 + i, tap_set[i] & 'hffff);
        wb_write(`DFE_REG_SYMCNT, 0);
        repeat (30) begin
            send_sample(int'(rand_next() % 401) - 200, lvl);
            stream_idle(int'(rand_next() % 4));
        end
        drain();
        wb_read(`DFE_REG_SYMCNT, rd);
        check_val("symcnt", 30, rd);
        // thresholds move to 0 and +-80
        wb_write(`DFE_REG_SEP, 80);
        repeat (20) begin
            send_sample(int'(rand_next() % 401) - 200, lvl);
            stream_idle(int'(rand_next() % 3));
        end
        drain();
        wb_read(`DFE_REG_SYMCNT, rd);
        check_val("symcnt", 50, rd);
        report_test("gaps", e0);
    endtask

    initial begin
        rstn         = 1'b0;
        sample       = '0;
        sample_valid = 1'b0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        m_en         = 0;
        m_sep        = `DFE_SEP_DEFAULT;
        m_sat        = 0;
        m_tap        = '{default: 0};
        m_hist       = '{default: 0};
        checks       = 0;
        errors       = 0;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        test_regs();
        test_slicer();
        test_isi();
        test_sat();
        test_gaps();
        errors += dut0.chk0.fail_cnt;
        $display("checks %0d, errors %0d, assertion failures %0d",
                 checks, errors, dut0.chk0.fail_cnt);
        if (errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/dfe_feedback.sv ====
// DFE feedback stage
`timescale 1ns/1ps
`default_nettype none

module dfe_feedback
    import dfe_pkg::*;
#(
    parameter int SAMPLE_W = 10,
    parameter int NUM_TAPS = 3,
    parameter int TAP_W    = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic signed [SAMPLE_W-1:0] sample,
    input  wire logic                       sample_valid,
    input  wire logic                       fb_enable,
    input  wire logic [SAMPLE_W-1:0]        separation,
    input  wire logic [NUM_TAPS*TAP_W-1:0]  taps,
    input  wire level_t                     dec_level,
    output logic signed [SAMPLE_W-1:0]      eq_sample,
    output logic                            eq_valid,
    output logic                            sat_pulse
);

    // room for tap*level summed over six taps, times separation/2
    localparam int ACC_W = SAMPLE_W + TAP_W + 8;
    localparam logic signed [ACC_W-1:0] EQ_MAX = (ACC_W'(1) <<< (SAMPLE_W - 1)) - 1;
    localparam logic signed [ACC_W-1:0] EQ_MIN = -(ACC_W'(1) <<< (SAMPLE_W - 1));

    level_t                  hist [NUM_TAPS];
    level_t                  eff  [NUM_TAPS];
    logic [SAMPLE_W-1:0]     half_sep;
    logic signed [ACC_W-1:0] tap_sum;
    logic signed [ACC_W-1:0] isi;
    logic signed [ACC_W-1:0] diff;
    logic signed [ACC_W-1:0] eq_next;
    logic                    clamp;

    // newest decision is still combinational from the slicer while eq_valid
    // is high, so fold it in ahead of the stored history
    always_comb begin
        eff[0] = eq_valid ? dec_level : hist[0];
        for (int k = 1; k < NUM_TAPS; k++) begin
            eff[k] = eq_valid ? hist[k-1] : hist[k];
        end
    end

    assign half_sep = separation >> 1;

    // isi = (sum tap[k]*level[k] * sep/2) >>> TAP_FRAC
    always_comb begin
        tap_sum = '0;
        for (int k = 0; k < NUM_TAPS; k++) begin
            tap_sum = tap_sum + $signed(taps[k*TAP_W +: TAP_W]) * eff[k];
        end
        isi = (tap_sum * $signed({1'b0, half_sep})) >>> TAP_FRAC;
    end

    always_comb begin
        if (fb_enable) begin
            diff = ACC_W'(sample) - isi;
        end else begin
            diff = ACC_W'(sample);
        end
        clamp = 1'b1;
        if (diff > EQ_MAX) begin
            eq_next = EQ_MAX;
        end else if (diff < EQ_MIN) begin
            eq_next = EQ_MIN;
        end else begin
            eq_next = diff;
            clamp   = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            eq_valid  <= 1'b0;
            sat_pulse <= 1'b0;
            eq_sample <= '0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                hist[k] <= '0;
            end
        end else begin
            eq_valid  <= sample_valid;
            sat_pulse <= sample_valid && clamp;
            if (sample_valid) begin
                eq_sample <= eq_next[SAMPLE_W-1:0];
            end
            // shift in the decision of the sample leaving this stage
            if (eq_valid) begin
                for (int k = 0; k < NUM_TAPS; k++) begin
                    hist[k] <= eff[k];
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dfe_pkg.sv ====
// PAM4 DFE shared types
`default_nettype none

package dfe_pkg;

    // Gray-coded PAM4 symbol
    typedef logic [1:0] pam4_sym_t;

    // decision level index, -3/-1/+1/+3 (0 only in the reset history)
    typedef logic signed [2:0] level_t;

    // fraction bits of the tap weights
    localparam int TAP_FRAC = 4;

    // Wishbone register port
    localparam int WB_ADR_W = 4;
    localparam int WB_DAT_W = 16;

    // neighbouring levels differ in one bit
    function automatic pam4_sym_t to_gray(input level_t lvl);
        pam4_sym_t g;
        case (lvl)
            -3:      g = 2'b00;
            -1:      g = 2'b01;
            1:       g = 2'b11;
            3:       g = 2'b10;
            default: g = 2'b00;
        endcase
        return g;
    endfunction

endpackage

`default_nettype wire

// ==== verilog/dfe_regs.sv ====
// DFE register block
`timescale 1ns/1ps
`default_nettype none
`include "dfe_defs.svh"

module dfe_regs
    import dfe_pkg::*;
#(
    parameter int SAMPLE_W = 10,
    parameter int NUM_TAPS = 3,
    parameter int TAP_W    = 8
) (
    input  wire logic                      clk,
    input  wire logic                      rstn,
    input  wire logic                      wb_cyc,
    input  wire logic                      wb_stb,
    input  wire logic                      wb_we,
    input  wire logic [WB_ADR_W-1:0]       wb_adr,
    input  wire logic [WB_DAT_W-1:0]       wb_dat_w,
    output logic      [WB_DAT_W-1:0]       wb_dat_r,
    output logic                           wb_ack,
    input  wire logic                      sym_valid,
    input  wire logic                      sat_pulse,
    output logic                           fb_enable,
    output logic      [SAMPLE_W-1:0]       separation,
    output logic      [NUM_TAPS*TAP_W-1:0] taps
);

    logic signed [TAP_W-1:0] tap_q [NUM_TAPS];
    logic [15:0]             sym_cnt;
    logic [15:0]             sat_cnt;
    logic                    req;
    logic                    wr_en;
    logic [WB_DAT_W-1:0]     rd_data;

    // new request seen while ack is low, ack follows on the next edge
    assign req   = wb_cyc && wb_stb && !wb_ack;
    assign wr_en = req && wb_we;

    always_comb begin
        for (int i = 0; i < NUM_TAPS; i++) begin
            taps[i*TAP_W +: TAP_W] = tap_q[i];
        end
    end

    // read mux, unmapped addresses give 0
    always_comb begin
        rd_data = '0;
        if (wb_adr == WB_ADR_W'(`DFE_REG_CTRL)) begin
            rd_data[0] = fb_enable;
        end else if (wb_adr == WB_ADR_W'(`DFE_REG_SEP)) begin
            rd_data = WB_DAT_W'(separation);
        end else if (wb_adr == WB_ADR_W'(`DFE_REG_SYMCNT)) begin
            rd_data = sym_cnt;
        end else if (wb_adr == WB_ADR_W'(`DFE_REG_SATCNT)) begin
            rd_data = sat_cnt;
        end
        for (int i = 0; i < NUM_TAPS; i++) begin
            if (wb_adr == WB_ADR_W'(`DFE_REG_TAP0 + i)) begin
                // sign-extend so software sees the weight as a 16-bit value
                rd_data = WB_DAT_W'(tap_q[i]);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            wb_ack     <= 1'b0;
            fb_enable  <= 1'b0;
            separation <= SAMPLE_W'(`DFE_SEP_DEFAULT);
            for (int i = 0; i < NUM_TAPS; i++) begin
                tap_q[i] <= '0;
            end
        end else begin
            wb_ack <= req;
            if (wr_en) begin
                if (wb_adr == WB_ADR_W'(`DFE_REG_CTRL)) begin
                    fb_enable <= wb_dat_w[0];
                end
                if (wb_adr == WB_ADR_W'(`DFE_REG_SEP)) begin
                    separation <= wb_dat_w[SAMPLE_W-1:0];
                end
                for (int i = 0; i < NUM_TAPS; i++) begin
                    if (wb_adr == WB_ADR_W'(`DFE_REG_TAP0 + i)) begin
                        tap_q[i] <= wb_dat_w[TAP_W-1:0];
                    end
                end
            end
        end
    end

    // read data is captured with the request and held while ack is high
    always_ff @(posedge clk) begin
        if (req) begin
            wb_dat_r <= rd_data;
        end
    end

    // wrapping counters, a write to the address clears and wins over a count
    always_ff @(posedge clk) begin
        if (!rstn) begin
            sym_cnt <= '0;
            sat_cnt <= '0;
        end else begin
            if (wr_en && wb_adr == WB_ADR_W'(`DFE_REG_SYMCNT)) begin
                sym_cnt <= '0;
            end else if (sym_valid) begin
                sym_cnt <= sym_cnt + 16'd1;
            end
            if (wr_en && wb_adr == WB_ADR_W'(`DFE_REG_SATCNT)) begin
                sat_cnt <= '0;
            end else if (sat_pulse) begin
                sat_cnt <= sat_cnt + 16'd1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/dfe_top.sv ====
// PAM4 receive equalizer top
`timescale 1ns/1ps
`default_nettype none

module dfe_top
    import dfe_pkg::*;
#(
    parameter int SAMPLE_W = 10,
    parameter int NUM_TAPS = 3,
    parameter int TAP_W    = 8
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic signed [SAMPLE_W-1:0] sample,
    input  wire logic                       sample_valid,
    output pam4_sym_t                       sym,
    output level_t                          sym_level,
    output logic signed [SAMPLE_W-1:0]      eq_sample,
    output logic                            sym_valid,
    input  wire logic                       wb_cyc,
    input  wire logic                       wb_stb,
    input  wire logic                       wb_we,
    input  wire logic [WB_ADR_W-1:0]        wb_adr,
    input  wire logic [WB_DAT_W-1:0]        wb_dat_w,
    output logic      [WB_DAT_W-1:0]        wb_dat_r,
    output logic                            wb_ack
);

    logic                       fb_enable;
    logic [SAMPLE_W-1:0]        separation;
    logic [NUM_TAPS*TAP_W-1:0]  taps;
    logic signed [SAMPLE_W-1:0] fb_eq;
    logic                       eq_valid;
    logic                       sat_pulse;
    level_t                     dec_level;

    dfe_regs #(
        .SAMPLE_W (SAMPLE_W),
        .NUM_TAPS (NUM_TAPS),
        .TAP_W    (TAP_W)
    ) u_regs (
        .clk        (clk),
        .rstn       (rstn),
        .wb_cyc     (wb_cyc),
        .wb_stb     (wb_stb),
        .wb_we      (wb_we),
        .wb_adr     (wb_adr),
        .wb_dat_w   (wb_dat_w),
        .wb_dat_r   (wb_dat_r),
        .wb_ack     (wb_ack),
        .sym_valid  (sym_valid),
        .sat_pulse  (sat_pulse),
        .fb_enable  (fb_enable),
        .separation (separation),
        .taps       (taps)
    );

    // stage 1, isi subtraction
    dfe_feedback #(
        .SAMPLE_W (SAMPLE_W),
        .NUM_TAPS (NUM_TAPS),
        .TAP_W    (TAP_W)
    ) u_feedback (
        .clk          (clk),
        .rstn         (rstn),
        .sample       (sample),
        .sample_valid (sample_valid),
        .fb_enable    (fb_enable),
        .separation   (separation),
        .taps         (taps),
        .dec_level    (dec_level),
        .eq_sample    (fb_eq),
        .eq_valid     (eq_valid),
        .sat_pulse    (sat_pulse)
    );

    // stage 2, decision and output register
    pam4_slicer #(
        .SAMPLE_W (SAMPLE_W)
    ) u_slicer (
        .clk        (clk),
        .rstn       (rstn),
        .eq_sample  (fb_eq),
        .eq_valid   (eq_valid),
        .separation (separation),
        .dec_level  (dec_level),
        .sym        (sym),
        .sym_level  (sym_level),
        .sym_out    (eq_sample),
        .sym_valid  (sym_valid)
    );

endmodule

`default_nettype wire

// ==== verilog/pam4_slicer.sv ====
// PAM4 decision slicer
`timescale 1ns/1ps
`default_nettype none

module pam4_slicer
    import dfe_pkg::*;
#(
    parameter int SAMPLE_W = 10
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic signed [SAMPLE_W-1:0] eq_sample,
    input  wire logic                       eq_valid,
    input  wire logic [SAMPLE_W-1:0]        separation,
    output level_t                          dec_level,
    output pam4_sym_t                       sym,
    output level_t                          sym_level,
    output logic signed [SAMPLE_W-1:0]      sym_out,
    output logic                            sym_valid
);

    logic signed [SAMPLE_W:0] eq_ext;
    logic signed [SAMPLE_W:0] sep_pos;
    logic signed [SAMPLE_W:0] sep_neg;

    // one extra bit so the full unsigned separation compares as signed
    assign eq_ext  = eq_sample;
    assign sep_pos = $signed({1'b0, separation});
    assign sep_neg = -sep_pos;

    // levels sit at +-sep/2 and +-3sep/2, so the midpoints are 0 and +-sep
    always_comb begin
        if (eq_ext >= sep_pos) begin
            dec_level = 3'sd3;
        end else if (eq_ext >= 0) begin
            dec_level = 3'sd1;
        end else if (eq_ext >= sep_neg) begin
            dec_level = -3'sd1;
        end else begin
            dec_level = -3'sd3;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            sym_valid <= 1'b0;
            sym       <= '0;
            sym_level <= '0;
            sym_out   <= '0;
        end else begin
            sym_valid <= eq_valid;
            if (eq_valid) begin
                sym       <= to_gray(dec_level);
                sym_level <= dec_level;
                sym_out   <= eq_sample;
            end
        end
    end

endmodule

`default_nettype wire
